/* hw/tmr_pkg.sv */
//--------------------------------------------------------------------------
// Shared widths, register map, mode enum and bus/config/vote structs
// for the TMR controller
//--------------------------------------------------------------------------
`default_nettype none

package tmr_pkg;

  localparam int unsigned DataWidth  = 32;
  localparam int unsigned CoreNum    = 3;
  localparam int unsigned CntWidth   = 16;
  localparam int unsigned WbAdrWidth = 8;
  localparam int unsigned WbDatWidth = 32;
  localparam int unsigned WbSelWidth = 4;

  typedef logic [DataWidth-1:0]  data_t;
  typedef logic [CoreNum-1:0]    core_vec_t;
  typedef logic [CntWidth-1:0]   cnt_t;
  typedef logic [WbAdrWidth-1:0] wb_adr_t;
  typedef logic [WbDatWidth-1:0] wb_dat_t;
  typedef logic [WbSelWidth-1:0] wb_sel_t;

  // Register byte addresses
  localparam wb_adr_t AdrCtrl   = 8'h00;
  localparam wb_adr_t AdrStatus = 8'h04;
  localparam wb_adr_t AdrCnt0   = 8'h08;
  localparam wb_adr_t AdrCnt1   = 8'h0C;
  localparam wb_adr_t AdrCnt2   = 8'h10;

  // Bit positions inside CTRL
  localparam int unsigned CtrlEnableBit        = 0;
  localparam int unsigned CtrlSetbackBit       = 1;
  localparam int unsigned CtrlReloadSetbackBit = 2;
  localparam int unsigned CtrlRapidBit         = 3;
  localparam int unsigned CtrlForceBit         = 4;

  typedef enum logic [2:0] {
    NON_TMR,
    TMR_RUN,
    TMR_UNLOAD,
    TMR_RELOAD,
    TMR_RAPID
  } tmr_mode_e;

  localparam tmr_mode_e ModeReset = NON_TMR;

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat;
    wb_sel_t sel;
  } wb_req_t;

  typedef struct packed {
    logic    ack;
    wb_dat_t dat;
  } wb_rsp_t;

  typedef struct packed {
    logic enable;
    logic setback;
    logic reload_setback;
    logic rapid_recovery;
    logic force_resynch;
  } tmr_cfg_t;

  typedef struct packed {
    data_t     voted;
    core_vec_t error;
    logic      single_mismatch;
    logic      failure;
  } vote_t;

endpackage

`default_nettype wire

/* hw/tmr_wb_regs.sv */
//--------------------------------------------------------------------------
// Wishbone classic slave: CTRL, STATUS and per-core saturating
// mismatch counters
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tmr_wb_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  tmr_pkg::wb_req_t   wb_req_i,
  output tmr_pkg::wb_rsp_t   wb_rsp_o,
  output tmr_pkg::tmr_cfg_t  cfg_o,
  input  tmr_pkg::tmr_mode_e mode_i,
  input  logic               force_clr_i,
  input  tmr_pkg::core_vec_t incr_i
);

  logic               req_valid;
  logic               wr_en;
  logic               ack_q;
  tmr_pkg::wb_dat_t   rdata_d;
  tmr_pkg::wb_dat_t   rdata_q;
  tmr_pkg::wb_dat_t   ctrl_rd;
  tmr_pkg::tmr_cfg_t  ctrl_q;
  tmr_pkg::core_vec_t cnt_clr;
  tmr_pkg::cnt_t      cnt_q [tmr_pkg::CoreNum];

  // New access only while ack is low, so each access is acked exactly once
  assign req_valid = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  // Only the low byte lane carries register bits
  assign wr_en     = req_valid & wb_req_i.we & wb_req_i.sel[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_valid;
    end
  end

  // CTRL image as seen on the bus
  always_comb begin
    ctrl_rd = '0;
    ctrl_rd[tmr_pkg::CtrlEnableBit]        = ctrl_q.enable;
    ctrl_rd[tmr_pkg::CtrlSetbackBit]       = ctrl_q.setback;
    ctrl_rd[tmr_pkg::CtrlReloadSetbackBit] = ctrl_q.reload_setback;
    ctrl_rd[tmr_pkg::CtrlRapidBit]         = ctrl_q.rapid_recovery;
    ctrl_rd[tmr_pkg::CtrlForceBit]         = ctrl_q.force_resynch;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else begin
      // FSM consumes the force request
      if (force_clr_i) begin
        ctrl_q.force_resynch <= 1'b0;
      end
      if (wr_en && wb_req_i.adr == tmr_pkg::AdrCtrl) begin
        ctrl_q.enable         <= wb_req_i.dat[tmr_pkg::CtrlEnableBit];
        ctrl_q.setback        <= wb_req_i.dat[tmr_pkg::CtrlSetbackBit];
        ctrl_q.reload_setback <= wb_req_i.dat[tmr_pkg::CtrlReloadSetbackBit];
        ctrl_q.rapid_recovery <= wb_req_i.dat[tmr_pkg::CtrlRapidBit];
        ctrl_q.force_resynch  <= wb_req_i.dat[tmr_pkg::CtrlForceBit];
      end
    end
  end

  assign cfg_o = ctrl_q;

  // Any write to a counter address clears that counter
  always_comb begin
    cnt_clr = '0;
    if (wr_en) begin
      case (wb_req_i.adr)
        tmr_pkg::AdrCnt0: cnt_clr[0] = 1'b1;
        tmr_pkg::AdrCnt1: cnt_clr[1] = 1'b1;
        tmr_pkg::AdrCnt2: cnt_clr[2] = 1'b1;
        default:          cnt_clr    = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < tmr_pkg::CoreNum; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < tmr_pkg::CoreNum; i++) begin
        if (cnt_clr[i]) begin
          cnt_q[i] <= '0;
        end else if (incr_i[i] && cnt_q[i] != '1) begin
          // Saturate at all ones
          cnt_q[i] <= cnt_q[i] + tmr_pkg::cnt_t'(1);
        end
      end
    end
  end

  // Read mux, unmapped addresses return zero
  always_comb begin
    case (wb_req_i.adr)
      tmr_pkg::AdrCtrl:   rdata_d = ctrl_rd;
      tmr_pkg::AdrStatus: rdata_d = tmr_pkg::wb_dat_t'(mode_i);
      tmr_pkg::AdrCnt0:   rdata_d = tmr_pkg::wb_dat_t'(cnt_q[0]);
      tmr_pkg::AdrCnt1:   rdata_d = tmr_pkg::wb_dat_t'(cnt_q[1]);
      tmr_pkg::AdrCnt2:   rdata_d = tmr_pkg::wb_dat_t'(cnt_q[2]);
      default:            rdata_d = '0;
    endcase
  end

  // Read data is captured together with ack
  always_ff @(posedge clk_i) begin
    if (req_valid) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

/* hw/tmr_voter.sv */
//--------------------------------------------------------------------------
// Bitwise two-of-three majority voter with error vector,
// single-mismatch and failure flags
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tmr_voter (
  input  tmr_pkg::data_t core0_i,
  input  tmr_pkg::data_t core1_i,
  input  tmr_pkg::data_t core2_i,
  output tmr_pkg::vote_t vote_o
);

  tmr_pkg::data_t     voted;
  tmr_pkg::core_vec_t error;
  logic               diff01;
  logic               diff12;
  logic               diff02;

  // Each bit takes the value held by at least two replicas
  assign voted = (core0_i & core1_i) |
                 (core0_i & core2_i) |
                 (core1_i & core2_i);

  // A replica is wrong when it disagrees with the majority anywhere
  assign error[0] = (core0_i != voted);
  assign error[1] = (core1_i != voted);
  assign error[2] = (core2_i != voted);

  assign diff01 = (core0_i != core1_i);
  assign diff12 = (core1_i != core2_i);
  assign diff02 = (core0_i != core2_i);

  assign vote_o.voted = voted;
  assign vote_o.error = error;

  // Exactly one replica off
  assign vote_o.single_mismatch = (error == 3'b001) ||
                                  (error == 3'b010) ||
                                  (error == 3'b100);

  // No two replicas agree, the voted word cannot be trusted
  assign vote_o.failure = diff01 & diff12 & diff02;

endmodule

`default_nettype wire

/* hw/tmr_mode_fsm.sv */
//--------------------------------------------------------------------------
// Redundancy-mode FSM: recovery requests, setbacks and counter increments
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tmr_mode_fsm (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  tmr_pkg::tmr_cfg_t  cfg_i,
  input  tmr_pkg::vote_t     vote_i,
  input  logic               fetch_en_i,
  input  logic               unload_done_i,
  input  logic               reload_done_i,
  input  logic               cores_synch_i,
  input  logic               recovery_done_i,
  output tmr_pkg::tmr_mode_e mode_o,
  output logic               force_clr_o,
  output tmr_pkg::core_vec_t incr_o,
  output tmr_pkg::core_vec_t setback_o,
  output logic               resynch_req_o,
  output logic               synch_req_o,
  output logic               recovery_req_o,
  output logic               grp_independent_o,
  output logic               rapid_en_o
);

  tmr_pkg::tmr_mode_e mode_d;
  tmr_pkg::tmr_mode_e mode_q;
  tmr_pkg::tmr_mode_e recover_mode;
  logic               any_mismatch;

  // Where a detected error sends the group
  assign recover_mode = cfg_i.rapid_recovery ? tmr_pkg::TMR_RAPID : tmr_pkg::TMR_UNLOAD;
  assign any_mismatch = vote_i.single_mismatch | vote_i.failure;

  always_comb begin
    mode_d         = mode_q;
    force_clr_o    = 1'b0;
    incr_o         = '0;
    setback_o      = '0;
    resynch_req_o  = 1'b0;
    synch_req_o    = 1'b0;
    recovery_req_o = 1'b0;

    case (mode_q)
      tmr_pkg::TMR_RUN: begin
        // Software-requested resync, consumed right away
        if (cfg_i.force_resynch) begin
          force_clr_o = 1'b1;
          mode_d      = recover_mode;
        end
        if (vote_i.single_mismatch) begin
          incr_o = vote_i.error;
          mode_d = recover_mode;
        end
      end

      tmr_pkg::TMR_UNLOAD: begin
        resynch_req_o = 1'b1;
        if (unload_done_i) begin
          mode_d = tmr_pkg::TMR_RELOAD;
          if (cfg_i.setback) begin
            setback_o = 3'b111;
          end
        end
      end

      tmr_pkg::TMR_RELOAD: begin
        if (reload_done_i) begin
          mode_d = tmr_pkg::TMR_RUN;
        end else if (any_mismatch && cfg_i.setback && cfg_i.reload_setback) begin
          // Fault during reload, restart all three cores
          setback_o = 3'b111;
        end
      end

      tmr_pkg::TMR_RAPID: begin
        recovery_req_o = 1'b1;
        if (recovery_done_i) begin
          mode_d = tmr_pkg::TMR_RUN;
        end
      end

      tmr_pkg::NON_TMR: begin
        mode_d = tmr_pkg::NON_TMR;
      end

      default: begin
        mode_d = tmr_pkg::ModeReset;
      end
    endcase

    // Until the cores fetch, the mode simply tracks the enable bit
    if (!fetch_en_i) begin
      mode_d = cfg_i.enable ? tmr_pkg::TMR_RUN : tmr_pkg::NON_TMR;
    end

    // Leaving TMR is allowed at any time from the run state
    if (mode_q == tmr_pkg::TMR_RUN && !cfg_i.enable) begin
      mode_d = tmr_pkg::NON_TMR;
      if (cfg_i.setback) begin
        setback_o = 3'b110;
      end
    end

    // Entering TMR needs the cores brought into step first
    if (mode_q == tmr_pkg::NON_TMR && cfg_i.enable) begin
      synch_req_o = 1'b1;
      if (cores_synch_i) begin
        mode_d = tmr_pkg::TMR_RELOAD;
        if (cfg_i.setback) begin
          setback_o = 3'b111;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q <= tmr_pkg::ModeReset;
    end else begin
      mode_q <= mode_d;
    end
  end

  assign mode_o            = mode_q;
  assign grp_independent_o = (mode_q == tmr_pkg::NON_TMR);
  assign rapid_en_o        = cfg_i.rapid_recovery;

endmodule

`default_nettype wire

/* hw/tmr_ctrl_top.sv */
//--------------------------------------------------------------------------
// TMR controller top: register file, majority voter and mode FSM
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tmr_ctrl_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Wishbone slave
  input  tmr_pkg::wb_req_t   wb_req_i,
  output tmr_pkg::wb_rsp_t   wb_rsp_o,
  // Core results
  input  tmr_pkg::data_t     core0_i,
  input  tmr_pkg::data_t     core1_i,
  input  tmr_pkg::data_t     core2_i,
  output tmr_pkg::data_t     voted_o,
  // Recovery handshakes
  input  logic               fetch_en_i,
  input  logic               unload_done_i,
  input  logic               reload_done_i,
  input  logic               cores_synch_i,
  input  logic               recovery_done_i,
  output tmr_pkg::core_vec_t setback_o,
  output logic               resynch_req_o,
  output logic               synch_req_o,
  output logic               recovery_req_o,
  output logic               grp_independent_o,
  output logic               rapid_en_o
);

  tmr_pkg::tmr_cfg_t  cfg;
  tmr_pkg::tmr_mode_e mode;
  tmr_pkg::core_vec_t incr;
  tmr_pkg::vote_t     vote;
  logic               force_clr;

  tmr_wb_regs u_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_req_i    (wb_req_i),
    .wb_rsp_o    (wb_rsp_o),
    .cfg_o       (cfg),
    .mode_i      (mode),
    .force_clr_i (force_clr),
    .incr_i      (incr)
  );

  tmr_voter u_voter (
    .core0_i (core0_i),
    .core1_i (core1_i),
    .core2_i (core2_i),
    .vote_o  (vote)
  );

  assign voted_o = vote.voted;

  tmr_mode_fsm u_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .cfg_i             (cfg),
    .vote_i            (vote),
    .fetch_en_i        (fetch_en_i),
    .unload_done_i     (unload_done_i),
    .reload_done_i     (reload_done_i),
    .cores_synch_i     (cores_synch_i),
    .recovery_done_i   (recovery_done_i),
    .mode_o            (mode),
    .force_clr_o       (force_clr),
    .incr_o            (incr),
    .setback_o         (setback_o),
    .resynch_req_o     (resynch_req_o),
    .synch_req_o       (synch_req_o),
    .recovery_req_o    (recovery_req_o),
    .grp_independent_o (grp_independent_o),
    .rapid_en_o        (rapid_en_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_tmr_ctrl.sv */
//--------------------------------------------------------------------------
// TMR controller testbench: Wishbone access tasks, typed compare tasks,
// stimulus table with expected results and a cycle-limit watchdog
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_tmr_ctrl;

  typedef struct packed {
    logic               wr_en;
    tmr_pkg::wb_adr_t   wr_adr;
    logic [7:0]         wr_dat;
    logic               fetch_en;
    tmr_pkg::core_vec_t fault;
    logic [3:0]         hs;       // unload, reload, synch, recovery done
    tmr_pkg::core_vec_t exp_sb;
    tmr_pkg::core_vec_t exp_req;  // resynch, synch, recovery
    tmr_pkg::tmr_mode_e exp_mode;
    tmr_pkg::cnt_t      exp_cnt0;
    tmr_pkg::cnt_t      exp_cnt1;
    tmr_pkg::cnt_t      exp_cnt2;
  } step_t;

  localparam int NumSteps  = 17;
  localparam int MaxCycles = 40 * NumSteps + 100;

  logic               clk_i;
  logic               rst_ni;
  tmr_pkg::wb_req_t   wb_req;
  tmr_pkg::wb_rsp_t   wb_rsp;
  tmr_pkg::data_t     core0;
  tmr_pkg::data_t     core1;
  tmr_pkg::data_t     core2;
  tmr_pkg::data_t     voted;
  logic               fetch_en;
  logic               unload_done;
  logic               reload_done;
  logic               cores_synch;
  logic               recovery_done;
  tmr_pkg::core_vec_t setback;
  logic               resynch_req;
  logic               synch_req;
  logic               recovery_req;
  logic               grp_independent;
  logic               rapid_en;
  step_t              tbl [NumSteps];
  tmr_pkg::core_vec_t sb_seen;
  tmr_pkg::core_vec_t req_seen;
  logic [7:0]         ctrl_img;
  tmr_pkg::data_t     base;
  int unsigned        flip;
  integer             seed;
  integer             cycles;
  integer             errors;
  integer             step_errs;
  integer             failed_steps;

  tmr_ctrl_top dut0 (
    .clk_i (clk_i), .rst_ni (rst_ni), .wb_req_i (wb_req), .wb_rsp_o (wb_rsp),
    .core0_i (core0), .core1_i (core1), .core2_i (core2), .voted_o (voted),
    .fetch_en_i (fetch_en), .unload_done_i (unload_done), .reload_done_i (reload_done),
    .cores_synch_i (cores_synch), .recovery_done_i (recovery_done), .setback_o (setback),
    .resynch_req_o (resynch_req), .synch_req_o (synch_req), .recovery_req_o (recovery_req),
    .grp_independent_o (grp_independent), .rapid_en_o (rapid_en)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", MaxCycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // Setback pulses and request levels seen during the current step
  always @(negedge clk_i) begin
    sb_seen  = sb_seen | setback;
    req_seen = req_seen | {resynch_req, synch_req, recovery_req};
  end

  task automatic check_data(input string name, input tmr_pkg::data_t got,
                            input tmr_pkg::data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      step_errs++;
    end
  endtask

  task automatic check_vec(input string name, input tmr_pkg::core_vec_t got,
                           input tmr_pkg::core_vec_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      step_errs++;
    end
  endtask

  task automatic check_mode(input string name, input tmr_pkg::tmr_mode_e got,
                            input tmr_pkg::tmr_mode_e exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      step_errs++;
    end
  endtask

  task automatic check_cnt(input string name, input tmr_pkg::cnt_t got,
                           input tmr_pkg::cnt_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      step_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      step_errs++;
    end
  endtask

  // Hold the cycle until the slave acks, then release the bus
  task automatic wait_ack(output tmr_pkg::wb_dat_t rd);
    do begin
      @(negedge clk_i);
    end while (!wb_rsp.ack);
    rd = wb_rsp.dat;
    @(posedge clk_i);
    wb_req.cyc <= 1'b0;
    wb_req.stb <= 1'b0;
    wb_req.we  <= 1'b0;
  endtask

  task automatic write_reg(input tmr_pkg::wb_adr_t adr, input tmr_pkg::wb_dat_t dat);
    tmr_pkg::wb_dat_t unused;
    @(posedge clk_i);
    wb_req.cyc <= 1'b1;
    wb_req.stb <= 1'b1;
    wb_req.we  <= 1'b1;
    wb_req.adr <= adr;
    wb_req.dat <= dat;
    wb_req.sel <= 4'hF;
    wait_ack(unused);
  endtask

  task automatic read_reg(input tmr_pkg::wb_adr_t adr, output tmr_pkg::wb_dat_t rd);
    @(posedge clk_i);
    wb_req.cyc <= 1'b1;
    wb_req.stb <= 1'b1;
    wb_req.we  <= 1'b0;
    wb_req.adr <= adr;
    wb_req.sel <= 4'hF;
    wait_ack(rd);
  endtask

  function automatic step_t step_row(
    input logic wr_en, input tmr_pkg::wb_adr_t adr, input logic [7:0] dat,
    input logic fetch, input tmr_pkg::core_vec_t fault, input logic [3:0] hs,
    input tmr_pkg::core_vec_t sb, input tmr_pkg::core_vec_t req,
    input tmr_pkg::tmr_mode_e mode, input tmr_pkg::cnt_t c0,
    input tmr_pkg::cnt_t c1, input tmr_pkg::cnt_t c2);
    step_t s;
    s = {wr_en, adr, dat, fetch, fault, hs, sb, req, mode, c0, c1, c2};
    return s;
  endfunction

  task automatic run_step(input int idx);
    step_t            s;
    tmr_pkg::wb_dat_t rd;
    s         = tbl[idx];
    step_errs = 0;
    sb_seen   = '0;
    req_seen  = '0;
    base      = $random(seed);
    flip      = $unsigned($random(seed)) % 30;
    if (s.wr_en) begin
      write_reg(s.wr_adr, tmr_pkg::wb_dat_t'(s.wr_dat));
      if (s.wr_adr == tmr_pkg::AdrCtrl) begin
        ctrl_img = s.wr_dat;
        // Force is only ever written in TMR_RUN, where the FSM consumes it
        read_reg(tmr_pkg::AdrCtrl, rd);
        check_data("ctrl", rd, tmr_pkg::data_t'(s.wr_dat & 8'hEF));
      end
    end
    @(posedge clk_i);
    core0         <= base ^ (s.fault[0] ? (32'h1 << flip) : 32'h0);
    core1         <= base ^ (s.fault[1] ? (32'h2 << flip) : 32'h0);
    core2         <= base ^ (s.fault[2] ? (32'h4 << flip) : 32'h0);
    fetch_en      <= s.fetch_en;
    unload_done   <= s.hs[3];
    reload_done   <= s.hs[2];
    cores_synch   <= s.hs[1];
    recovery_done <= s.hs[0];
    @(negedge clk_i);
    // Every bit is flipped in one replica at most, so the majority is the base word
    check_data("voted_o", voted, base);
    check_vec("error", dut0.vote.error, s.fault);
    @(posedge clk_i);
    core0         <= base;
    core1         <= base;
    core2         <= base;
    unload_done   <= 1'b0;
    reload_done   <= 1'b0;
    cores_synch   <= 1'b0;
    recovery_done <= 1'b0;
    read_reg(tmr_pkg::AdrStatus, rd);
    check_mode("mode", tmr_pkg::tmr_mode_e'(rd[2:0]), s.exp_mode);
    read_reg(tmr_pkg::AdrCnt0, rd);
    check_cnt("cnt0", rd[15:0], s.exp_cnt0);
    read_reg(tmr_pkg::AdrCnt1, rd);
    check_cnt("cnt1", rd[15:0], s.exp_cnt1);
    read_reg(tmr_pkg::AdrCnt2, rd);
    check_cnt("cnt2", rd[15:0], s.exp_cnt2);
    check_vec("setback_o", sb_seen, s.exp_sb);
    check_vec("requests", req_seen, s.exp_req);
    // Independent group only outside TMR, rapid enable taken from CTRL
    @(negedge clk_i);
    check_bit("grp_independent_o", grp_independent, s.exp_mode == tmr_pkg::NON_TMR);
    check_bit("rapid_en_o", rapid_en, ctrl_img[tmr_pkg::CtrlRapidBit]);
    @(posedge clk_i);
    $display("step %0d: %s", idx, (step_errs == 0) ? "ok" : "mismatch");
    errors = errors + step_errs;
    if (step_errs != 0) begin
      failed_steps = failed_steps + 1;
    end
  endtask

  initial begin
    seed          = 32'hc840;
    cycles        = 0;
    errors        = 0;
    failed_steps  = 0;
    sb_seen       = '0;
    req_seen      = '0;
    ctrl_img      = '0;
    rst_ni        = 1'b0;
    wb_req        = '0;
    core0         = '0;
    core1         = '0;
    core2         = '0;
    fetch_en      = 1'b0;
    unload_done   = 1'b0;
    reload_done   = 1'b0;
    cores_synch   = 1'b0;
    recovery_done = 1'b0;
    // wr_en, adr, ctrl data, fetch, fault, done hs, setback, req, mode, cnt0..2
    tbl[0] = step_row(0, 'h00, 'h00, 0, 3'b000, 4'h0, 3'b000, 3'b000, tmr_pkg::NON_TMR, 0, 0, 0);
    tbl[1] = step_row(1, 'h00, 'h03, 0, 3'b000, 4'h0, 3'b000, 3'b010, tmr_pkg::TMR_RUN, 0, 0, 0);
    tbl[2] = step_row(0, 'h00, 'h00, 1, 3'b010, 4'h0, 3'b000, 3'b100, tmr_pkg::TMR_UNLOAD, 0, 1, 0);
    tbl[3] = step_row(0, 'h00, 'h00, 1, 3'b000, 4'h8, 3'b111, 3'b100, tmr_pkg::TMR_RELOAD, 0, 1, 0);
    tbl[4] = step_row(0, 'h00, 'h00, 1, 3'b000, 4'h4, 3'b000, 3'b000, tmr_pkg::TMR_RUN, 0, 1, 0);
    tbl[5] = step_row(1, 'h0C, 'h00, 1, 3'b000, 4'h0, 3'b000, 3'b000, tmr_pkg::TMR_RUN, 0, 0, 0);
    // Rapid recovery, by mismatch and then by a force write
    tbl[6] = step_row(1, 'h00, 'h0B, 1, 3'b001, 4'h0, 3'b000, 3'b001, tmr_pkg::TMR_RAPID, 1, 0, 0);
    tbl[7] = step_row(0, 'h00, 'h00, 1, 3'b000, 4'h1, 3'b000, 3'b001, tmr_pkg::TMR_RUN, 1, 0, 0);
    tbl[8] = step_row(1, 'h00, 'h1B, 1, 3'b000, 4'h1, 3'b000, 3'b001, tmr_pkg::TMR_RUN, 1, 0, 0);
    // Failure of all three replicas while reloading
    tbl[9] = step_row(1, 'h00, 'h07, 1, 3'b100, 4'h0, 3'b000, 3'b100, tmr_pkg::TMR_UNLOAD, 1, 0, 1);
    tbl[10] = step_row(0, 'h00, 'h00, 1, 3'b000, 4'h8, 3'b111, 3'b100, tmr_pkg::TMR_RELOAD, 1, 0, 1);
    tbl[11] = step_row(0, 'h00, 'h00, 1, 3'b111, 4'h0, 3'b111, 3'b000, tmr_pkg::TMR_RELOAD, 1, 0, 1);
    tbl[12] = step_row(0, 'h00, 'h00, 1, 3'b000, 4'h4, 3'b000, 3'b000, tmr_pkg::TMR_RUN, 1, 0, 1);
    // Leave TMR, then come back through synch
    tbl[13] = step_row(1, 'h00, 'h06, 1, 3'b000, 4'h0, 3'b110, 3'b000, tmr_pkg::NON_TMR, 1, 0, 1);
    tbl[14] = step_row(1, 'h00, 'h03, 1, 3'b000, 4'h0, 3'b000, 3'b010, tmr_pkg::NON_TMR, 1, 0, 1);
    tbl[15] = step_row(0, 'h00, 'h00, 1, 3'b000, 4'h2, 3'b111, 3'b010, tmr_pkg::TMR_RELOAD, 1, 0, 1);
    tbl[16] = step_row(1, 'h08, 'h00, 1, 3'b000, 4'h4, 3'b000, 3'b000, tmr_pkg::TMR_RUN, 0, 0, 1);
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < NumSteps; i++) begin
      run_step(i);
    end
    $display("Failed checks: %0d, failed steps: %0d of %0d", errors, failed_steps, NumSteps);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
hw/tmr_pkg.sv
hw/tmr_wb_regs.sv
hw/tmr_voter.sv
hw/tmr_mode_fsm.sv
hw/tmr_ctrl_top.sv
testbench/tb_tmr_ctrl.sv

/* Bender.yml */
package:
  name: tmr_ctrl

sources:
  - files:
      - hw/tmr_pkg.sv
      - hw/tmr_wb_regs.sv
      - hw/tmr_voter.sv
      - hw/tmr_mode_fsm.sv
      - hw/tmr_ctrl_top.sv
  - target: test
    files:
      - testbench/tb_tmr_ctrl.sv
